//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = mem_port_tb
FILELIST = tb.f
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

//--- src/mem_chan_arbiter.sv
`default_nettype none

module mem_chan_arbiter (
	input  wire                             clk,
	input  wire                             rst,
	input  wire [mem_port_pkg::NCH-1:0]     req,
	input  wire                             advance,
	output mem_port_pkg::chan_t             grant_ch,
	output logic                            grant_any
);

	// Channel that has the highest priority in the current search
	mem_port_pkg::chan_t ptr;

	// ============================================================
	// Grant search
	// ============================================================

	// Walk the request lines starting at the pointer and take the first one
	// that is set. The index wraps naturally because NCH fills the chan_t range
	always_comb begin
		mem_port_pkg::chan_t idx;
		grant_any = 1'b0;
		grant_ch = ptr;
		for (int i = 0; i < mem_port_pkg::NCH; i++) begin
			idx = ptr + mem_port_pkg::chan_t'(i);
			if (!grant_any && req[idx]) begin
				grant_any = 1'b1;
				grant_ch = idx;
			end
		end
	end

	// ============================================================
	// Priority pointer
	// ============================================================

	// When the sequencer takes the grant the pointer moves to the channel just
	// after the one served. That channel drops to lowest priority, so every
	// waiting channel gets a turn within NCH grants
	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= '0;
		end else if (advance) begin
			ptr <= mem_port_pkg::chan_t'(grant_ch + 1'b1);
		end
	end

endmodule

`default_nettype wire

//--- src/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

	// ============================================================
	// Counts and widths
	// ============================================================

	// Four requesting channels share the port
	localparam int NCH = 4;
	localparam int CH_W = 2;

	// Two reservation buckets and the width of a bucket index
	localparam int NAR = 2;
	localparam int BK_W = $clog2(NAR);

	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	localparam int OP_W = 2;

	// A reservation covers one 16-byte line, so the line number starts at bit 4
	localparam int LINE_LSB = 4;
	localparam int LINE_W = ADR_W - LINE_LSB;

	// The memory holds 256 words and is indexed by address bits 9 down to 2
	localparam int MEM_WORDS = 256;
	localparam int WIDX_LSB = 2;
	localparam int WIDX_W = $clog2(MEM_WORDS);

	// Timeout register and bucket age counters
	localparam int TO_W = 16;

	// ============================================================
	// Types and encodings
	// ============================================================

	typedef logic [CH_W-1:0]   chan_t;
	typedef logic [ADR_W-1:0]  adr_t;
	typedef logic [DAT_W-1:0]  data_t;
	typedef logic [OP_W-1:0]   op_t;
	typedef logic [TO_W-1:0]   tmo_t;
	typedef logic [LINE_W-1:0] line_t;

	// Request operations
	localparam op_t OP_READ  = 2'd0;
	localparam op_t OP_WRITE = 2'd1;
	localparam op_t OP_LR    = 2'd2;
	localparam op_t OP_SC    = 2'd3;

	// Only a refused store-conditional reports a failure status
	localparam logic SC_OK   = 1'b0;
	localparam logic SC_FAIL = 1'b1;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESP
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/mem_port_sequencer.sv
`default_nettype none

module mem_port_sequencer (
	input  wire                                       clk,
	input  wire                                       rst,
	input  wire [mem_port_pkg::NCH-1:0]               req_valid,
	input  wire [mem_port_pkg::NCH*mem_port_pkg::OP_W-1:0]  req_op,
	input  wire [mem_port_pkg::NCH*mem_port_pkg::ADR_W-1:0] req_adr,
	input  wire [mem_port_pkg::NCH*mem_port_pkg::DAT_W-1:0] req_wdata,
	output logic [mem_port_pkg::NCH-1:0]              req_ready,
	input  mem_port_pkg::chan_t                       grant_ch,
	input  wire                                       grant_any,
	output logic                                      advance,
	output logic                                      mem_we,
	output mem_port_pkg::adr_t                        mem_adr,
	output mem_port_pkg::data_t                       mem_wdata,
	input  mem_port_pkg::data_t                       mem_rdata,
	output logic                                      rsv_set,
	output mem_port_pkg::chan_t                       rsv_ch,
	output mem_port_pkg::adr_t                        rsv_adr,
	input  wire                                       held,
	output logic                                      wr_done,
	output mem_port_pkg::adr_t                        wr_adr,
	output logic                                      resp_valid,
	output mem_port_pkg::chan_t                       resp_ch,
	output mem_port_pkg::data_t                       resp_rdata,
	output logic                                      resp_status,
	input  wire                                       resp_ready
);

	mem_port_pkg::seq_state_t state;

	// Request latched at accept time
	mem_port_pkg::chan_t cur_ch;
	mem_port_pkg::op_t   cur_op;
	mem_port_pkg::adr_t  cur_adr;
	mem_port_pkg::data_t cur_wdata;
	logic                status_q;

	logic accept;
	logic is_sc;
	logic is_read;

	// ============================================================
	// Accept
	// ============================================================

	// The grant is taken only in IDLE. grant_any already implies that the
	// granted channel has valid high, so ready and valid meet in this cycle
	assign accept = (state == mem_port_pkg::IDLE) && grant_any;
	assign advance = accept;

	always_comb begin
		req_ready = '0;
		if (accept) begin
			req_ready[grant_ch] = 1'b1;
		end
	end

	// ============================================================
	// Memory and reservation strobes
	// ============================================================

	assign is_sc = (cur_op == mem_port_pkg::OP_SC);
	assign is_read = (cur_op == mem_port_pkg::OP_READ) || (cur_op == mem_port_pkg::OP_LR);

	// The address stays on the latched request in every state. Nothing writes
	// memory outside ACCESS, so the read data stays stable while RESP waits
	assign mem_adr = cur_adr;
	assign mem_wdata = cur_wdata;
	assign rsv_ch = cur_ch;
	assign rsv_adr = cur_adr;
	assign wr_adr = cur_adr;

	// A store-conditional writes only while its channel holds the line
	assign mem_we = (state == mem_port_pkg::ACCESS) &&
		((cur_op == mem_port_pkg::OP_WRITE) || (is_sc && held));
	assign rsv_set = (state == mem_port_pkg::ACCESS) && (cur_op == mem_port_pkg::OP_LR);
	// Every write that really happens clears the reservations on its line
	assign wr_done = mem_we;

	// ============================================================
	// Response
	// ============================================================

	assign resp_valid = (state == mem_port_pkg::RESP);
	assign resp_ch = cur_ch;
	assign resp_status = status_q;
	// Writes and store-conditionals return zero data
	assign resp_rdata = is_read ? mem_rdata : '0;

	// ============================================================
	// State machine
	// ============================================================

	// Accept, access and response take one cycle each, and RESP stretches
	// for as long as the response is not taken
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_port_pkg::IDLE;
		end else begin
			case (state)
				mem_port_pkg::IDLE: begin
					if (accept) begin
						state <= mem_port_pkg::ACCESS;
					end
				end
				mem_port_pkg::ACCESS: begin
					state <= mem_port_pkg::RESP;
				end
				mem_port_pkg::RESP: begin
					if (resp_ready) begin
						state <= mem_port_pkg::IDLE;
					end
				end
				default: begin
					state <= mem_port_pkg::IDLE;
				end
			endcase
		end
	end

	// Request fields of the granted channel are sliced out of the flat vectors
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_ch <= grant_ch;
			cur_op <= req_op[grant_ch*mem_port_pkg::OP_W +: mem_port_pkg::OP_W];
			cur_adr <= req_adr[grant_ch*mem_port_pkg::ADR_W +: mem_port_pkg::ADR_W];
			cur_wdata <= req_wdata[grant_ch*mem_port_pkg::DAT_W +: mem_port_pkg::DAT_W];
		end
		// The held answer is only valid in ACCESS, so the status is caught there
		if (state == mem_port_pkg::ACCESS) begin
			status_q <= (is_sc && !held) ? mem_port_pkg::SC_FAIL : mem_port_pkg::SC_OK;
		end
	end

endmodule

`default_nettype wire

//--- src/mem_port_top.sv
`default_nettype none

module mem_port_top (
	input  wire                                       clk,
	input  wire                                       rst,
	input  wire [mem_port_pkg::NCH-1:0]               req_valid,
	input  wire [mem_port_pkg::NCH*mem_port_pkg::OP_W-1:0]  req_op,
	input  wire [mem_port_pkg::NCH*mem_port_pkg::ADR_W-1:0] req_adr,
	input  wire [mem_port_pkg::NCH*mem_port_pkg::DAT_W-1:0] req_wdata,
	output logic [mem_port_pkg::NCH-1:0]              req_ready,
	output logic                                      resp_valid,
	output mem_port_pkg::chan_t                       resp_ch,
	output mem_port_pkg::data_t                       resp_rdata,
	output logic                                      resp_status,
	input  wire                                       resp_ready,
	input  wire                                       cfg_we,
	input  mem_port_pkg::tmo_t                        cfg_tmo
);

	// Arbiter to sequencer
	mem_port_pkg::chan_t grant_ch;
	logic                grant_any;
	logic                advance;

	// Sequencer to word store
	logic                mem_we;
	mem_port_pkg::adr_t  mem_adr;
	mem_port_pkg::data_t mem_wdata;
	mem_port_pkg::data_t mem_rdata;

	// Sequencer to reservation manager
	logic                rsv_set;
	mem_port_pkg::chan_t rsv_ch;
	mem_port_pkg::adr_t  rsv_adr;
	logic                held;
	logic                wr_done;
	mem_port_pkg::adr_t  wr_adr;

	// Configuration to reservation manager
	mem_port_pkg::tmo_t  tmo;

	// ============================================================
	// Instances
	// ============================================================

	// The request valid lines double as the arbiter request vector
	mem_chan_arbiter u_arb (
		.clk       (clk),
		.rst       (rst),
		.req       (req_valid),
		.advance   (advance),
		.grant_ch  (grant_ch),
		.grant_any (grant_any)
	);

	mem_port_sequencer u_seq (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_adr     (req_adr),
		.req_wdata   (req_wdata),
		.req_ready   (req_ready),
		.grant_ch    (grant_ch),
		.grant_any   (grant_any),
		.advance     (advance),
		.mem_we      (mem_we),
		.mem_adr     (mem_adr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata),
		.rsv_set     (rsv_set),
		.rsv_ch      (rsv_ch),
		.rsv_adr     (rsv_adr),
		.held        (held),
		.wr_done     (wr_done),
		.wr_adr      (wr_adr),
		.resp_valid  (resp_valid),
		.resp_ch     (resp_ch),
		.resp_rdata  (resp_rdata),
		.resp_status (resp_status),
		.resp_ready  (resp_ready)
	);

	mem_resv_manager u_resv (
		.clk     (clk),
		.rst     (rst),
		.tmo     (tmo),
		.rsv_set (rsv_set),
		.rsv_ch  (rsv_ch),
		.rsv_adr (rsv_adr),
		.wr_done (wr_done),
		.wr_adr  (wr_adr),
		.held    (held)
	);

	mem_resv_cfg u_cfg (
		.clk     (clk),
		.rst     (rst),
		.cfg_we  (cfg_we),
		.cfg_tmo (cfg_tmo),
		.tmo     (tmo)
	);

	mem_word_store u_mem (
		.clk   (clk),
		.we    (mem_we),
		.adr   (mem_adr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- src/mem_resv_cfg.sv
`default_nettype none

module mem_resv_cfg (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 cfg_we,
	input  mem_port_pkg::tmo_t  cfg_tmo,
	output mem_port_pkg::tmo_t  tmo
);

	// ============================================================
	// Reservation policy registers
	// ============================================================

	// Reservation timeout in clock cycles
	// A bucket is freed once its age reaches this value
	// Zero turns expiry off and reservations then live until a write or a
	// replacement removes them
	mem_port_pkg::tmo_t tmo_q;

	// The system writes the timeout through a plain strobe with no handshake.
	// The new value is seen by the reservation manager from the next clock on
	always_ff @(posedge clk) begin
		if (rst) begin
			tmo_q <= '0;
		end else if (cfg_we) begin
			tmo_q <= cfg_tmo;
		end
	end

	// Further policy settings for the reservation manager belong beside this one
	assign tmo = tmo_q;

endmodule

`default_nettype wire

//--- src/mem_resv_manager.sv
`default_nettype none

module mem_resv_manager (
	input  wire                  clk,
	input  wire                  rst,
	input  mem_port_pkg::tmo_t   tmo,
	input  wire                  rsv_set,
	input  mem_port_pkg::chan_t  rsv_ch,
	input  mem_port_pkg::adr_t   rsv_adr,
	input  wire                  wr_done,
	input  mem_port_pkg::adr_t   wr_adr,
	output logic                 held
);

	// ============================================================
	// Bucket storage
	// ============================================================

	// Each bucket remembers which channel reserved which line and how many
	// cycles ago the reservation was made
	logic                 b_valid [mem_port_pkg::NAR];
	mem_port_pkg::chan_t  b_ch    [mem_port_pkg::NAR];
	mem_port_pkg::line_t  b_line  [mem_port_pkg::NAR];
	mem_port_pkg::tmo_t   b_age   [mem_port_pkg::NAR];

	// Bucket to throw out when a new reservation finds no empty bucket
	logic [mem_port_pkg::BK_W-1:0] victim;

	logic [mem_port_pkg::NAR-1:0]  expired;
	logic [mem_port_pkg::NAR-1:0]  live;
	logic                          found_free;
	logic [mem_port_pkg::BK_W-1:0] free_idx;
	logic [mem_port_pkg::BK_W-1:0] target;
	mem_port_pkg::line_t           set_line;
	mem_port_pkg::line_t           wr_line;

	// Line numbers of the address under check and of the completed write
	assign set_line = rsv_adr[mem_port_pkg::ADR_W-1:mem_port_pkg::LINE_LSB];
	assign wr_line = wr_adr[mem_port_pkg::ADR_W-1:mem_port_pkg::LINE_LSB];

	// A bucket whose age has reached a nonzero timeout already counts as free,
	// even though its valid flag is only cleared at the next edge
	always_comb begin
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			expired[i] = b_valid[i] && (tmo != '0) && (b_age[i] >= tmo);
			live[i] = b_valid[i] && !expired[i];
		end
	end

	// ============================================================
	// Held check and free-bucket search
	// ============================================================

	// The channel holds the line if any live bucket carries both
	always_comb begin
		held = 1'b0;
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			if (live[i] && b_ch[i] == rsv_ch && b_line[i] == set_line) begin
				held = 1'b1;
			end
		end
	end

	// Lowest numbered empty bucket
	always_comb begin
		found_free = 1'b0;
		free_idx = '0;
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			if (!live[i] && !found_free) begin
				found_free = 1'b1;
				free_idx = mem_port_pkg::BK_W'(i);
			end
		end
	end

	// A new reservation goes to an empty bucket when there is one, else to the victim
	assign target = found_free ? free_idx : victim;

	// ============================================================
	// Bucket updates
	// ============================================================

	// Only one operation is in flight, so a set and a write clear never arrive
	// in the same cycle. A set is still placed last so that it wins over aging
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= '0;
			for (int i = 0; i < mem_port_pkg::NAR; i++) begin
				b_valid[i] <= 1'b0;
				b_age[i] <= '0;
			end
		end else begin
			for (int i = 0; i < mem_port_pkg::NAR; i++) begin
				// Age saturates so that a long life with expiry off cannot wrap
				if (b_valid[i] && b_age[i] != '1) begin
					b_age[i] <= b_age[i] + 1'b1;
				end
				if (expired[i]) begin
					b_valid[i] <= 1'b0;
				end
				// Any write to the line kills every reservation on it, whoever holds it
				if (wr_done && b_valid[i] && b_line[i] == wr_line) begin
					b_valid[i] <= 1'b0;
				end
			end

			// A load-reserved of a line the channel already holds changes nothing.
			// A load-reserved loop then cannot use up the buckets
			if (rsv_set && !held) begin
				b_valid[target] <= 1'b1;
				b_ch[target] <= rsv_ch;
				b_line[target] <= set_line;
				b_age[target] <= '0;
				// The victim pointer only moves when it was actually used
				if (!found_free) begin
					if (victim == mem_port_pkg::BK_W'(mem_port_pkg::NAR - 1)) begin
						victim <= '0;
					end else begin
						victim <= victim + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/mem_word_store.sv
`default_nettype none

module mem_word_store (
	input  wire                  clk,
	input  wire                  we,
	input  mem_port_pkg::adr_t   adr,
	input  mem_port_pkg::data_t  wdata,
	output mem_port_pkg::data_t  rdata
);

	// ============================================================
	// Storage array
	// ============================================================

	// Word memory of MEM_WORDS entries
	mem_port_pkg::data_t mem [mem_port_pkg::MEM_WORDS];

	// Word index taken from the address above the byte offset
	logic [mem_port_pkg::WIDX_W-1:0] widx;

	assign widx = adr[mem_port_pkg::WIDX_LSB +: mem_port_pkg::WIDX_W];

	// One access per cycle
	// A write lands at the edge and the read data is registered, so the
	// read value appears one cycle after the address. In a write cycle the
	// read port returns the old contents of the word
	always_ff @(posedge clk) begin
		if (we) begin
			mem[widx] <= wdata;
		end
		rdata <= mem[widx];
	end

endmodule

`default_nettype wire

//--- tb.f
src/mem_port_pkg.sv
src/mem_chan_arbiter.sv
src/mem_resv_cfg.sv
src/mem_resv_manager.sv
src/mem_word_store.sv
src/mem_port_sequencer.sv
src/mem_port_top.sv
verif/mem_port_tb.sv

//--- verif/mem_port_tb.sv
`default_nettype none

module mem_port_tb;

	logic clk;
	logic rst;
	logic [mem_port_pkg::NCH-1:0] req_valid;
	logic [mem_port_pkg::NCH*mem_port_pkg::OP_W-1:0] req_op;
	logic [mem_port_pkg::NCH*mem_port_pkg::ADR_W-1:0] req_adr;
	logic [mem_port_pkg::NCH*mem_port_pkg::DAT_W-1:0] req_wdata;
	logic [mem_port_pkg::NCH-1:0] req_ready;
	logic resp_valid;
	mem_port_pkg::chan_t resp_ch;
	mem_port_pkg::data_t resp_rdata;
	logic resp_status;
	logic resp_ready;
	logic cfg_we;
	mem_port_pkg::tmo_t cfg_tmo;

	// The driver counts issued requests and the checker counts answered ones
	int cyc;
	int n_total;
	int n_issued [mem_port_pkg::NCH];
	int n_answered [mem_port_pkg::NCH];
	int acc_cyc [mem_port_pkg::NCH];
	mem_port_pkg::op_t pend_op [mem_port_pkg::NCH];
	mem_port_pkg::adr_t pend_adr [mem_port_pkg::NCH];
	mem_port_pkg::data_t pend_wdata [mem_port_pkg::NCH];
	logic bp_en;
	int err_count;
	int n_checks;
	int last_ch;
	int test_base;

	// Reference memory and reservation buckets
	mem_port_pkg::data_t m_mem [mem_port_pkg::MEM_WORDS];
	logic m_valid [mem_port_pkg::NAR];
	mem_port_pkg::chan_t m_ch [mem_port_pkg::NAR];
	mem_port_pkg::line_t m_line [mem_port_pkg::NAR];
	int m_set [mem_port_pkg::NAR];
	int m_victim;
	mem_port_pkg::tmo_t m_tmo;

	mem_port_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_adr     (req_adr),
		.req_wdata   (req_wdata),
		.req_ready   (req_ready),
		.resp_valid  (resp_valid),
		.resp_ch     (resp_ch),
		.resp_rdata  (resp_rdata),
		.resp_status (resp_status),
		.resp_ready  (resp_ready),
		.cfg_we      (cfg_we),
		.cfg_tmo     (cfg_tmo)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// The cycle index is read at the falling edge where it is stable
	always @(posedge clk) cyc <= cyc + 1;

	// Back-pressure is random while enabled and the response is always taken otherwise
	initial begin
		resp_ready = 1'b0;
		forever begin
			@(posedge clk);
			resp_ready <= bp_en ? ($urandom % 2 == 1) : 1'b1;
		end
	end

	// ============================================================
	// Reference model
	// ============================================================

	// Fill value that depends on every bit of the address
	function automatic mem_port_pkg::data_t fill_word(input mem_port_pkg::adr_t adr);
		return (adr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
	endfunction

	// A write to a line frees every reservation on it, whichever channel holds it
	function automatic void clear_line_reservations(input mem_port_pkg::line_t line);
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			if (m_valid[i] && m_line[i] == line) begin
				m_valid[i] = 1'b0;
			end
		end
	endfunction

	// Applies one request in its access cycle acc and gives the expected response
	function automatic void model_apply(
		input  mem_port_pkg::chan_t ch,
		input  mem_port_pkg::op_t   op,
		input  mem_port_pkg::adr_t  adr,
		input  mem_port_pkg::data_t wdata,
		input  int                  acc,
		output mem_port_pkg::data_t rdata,
		output logic                status
	);
		mem_port_pkg::line_t line;
		logic [mem_port_pkg::WIDX_W-1:0] widx;
		logic held;
		int slot;
		line = adr[mem_port_pkg::ADR_W-1:mem_port_pkg::LINE_LSB];
		widx = adr[mem_port_pkg::WIDX_LSB +: mem_port_pkg::WIDX_W];
		rdata = '0;
		status = mem_port_pkg::SC_OK;
		held = 1'b0;
		slot = -1;
		// A bucket counts one per cycle after the edge that set it
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			if (m_valid[i] && m_tmo != '0 && acc - m_set[i] - 1 >= int'(m_tmo)) begin
				m_valid[i] = 1'b0;
			end
		end
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			if (m_valid[i] && m_ch[i] == ch && m_line[i] == line) begin
				held = 1'b1;
			end
		end
		case (op)
			mem_port_pkg::OP_READ: begin
				rdata = m_mem[widx];
			end
			mem_port_pkg::OP_WRITE: begin
				m_mem[widx] = wdata;
				clear_line_reservations(line);
			end
			mem_port_pkg::OP_LR: begin
				rdata = m_mem[widx];
				// First empty bucket, or the rotating victim when all are taken
				if (!held) begin
					for (int i = 0; i < mem_port_pkg::NAR; i++) begin
						if (!m_valid[i] && slot < 0) begin
							slot = i;
						end
					end
					if (slot < 0) begin
						slot = m_victim;
						m_victim = (m_victim + 1) % mem_port_pkg::NAR;
					end
					m_valid[slot] = 1'b1;
					m_ch[slot] = ch;
					m_line[slot] = line;
					m_set[slot] = acc;
				end
			end
			default: begin
				if (held) begin
					m_mem[widx] = wdata;
					clear_line_reservations(line);
				end else begin
					status = mem_port_pkg::SC_FAIL;
				end
			end
		endcase
	endfunction

	// Next channel with an open request, searched from the one after the last served
	function automatic int next_pending();
		int c;
		next_pending = -1;
		for (int k = 1; k <= mem_port_pkg::NCH; k++) begin
			c = (last_ch + k) % mem_port_pkg::NCH;
			if (next_pending < 0 && n_issued[c] != n_answered[c]) begin
				next_pending = c;
			end
		end
	endfunction

	function automatic int count_outstanding();
		count_outstanding = 0;
		for (int c = 0; c < mem_port_pkg::NCH; c++) begin
			count_outstanding += n_issued[c] - n_answered[c];
		end
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] expected,
		input logic [31:0] got);
		err_count++;
		$display("error at %0t: %s expected %h, got %h", $time, sig, expected, got);
	endtask

	// ============================================================
	// Response checker
	// ============================================================

	// A response is taken at a falling edge that sees valid and ready together
	initial begin
		mem_port_pkg::data_t exp_rdata;
		logic exp_status;
		int exp_ch;
		logic in_resp;
		in_resp = 1'b0;
		exp_ch = -1;
		last_ch = mem_port_pkg::NCH - 1;
		m_victim = 0;
		for (int i = 0; i < mem_port_pkg::NAR; i++) begin
			m_valid[i] = 1'b0;
		end
		forever begin
			@(negedge clk);
			if (!rst && resp_valid) begin
				// The response must first show two cycles after its accept
				if (!in_resp) begin
					in_resp = 1'b1;
					exp_ch = next_pending();
					if (exp_ch >= 0 && cyc != acc_cyc[exp_ch] + 2) begin
						report_mismatch("resp_valid rise cycle", 32'(acc_cyc[exp_ch] + 2),
							32'(cyc));
					end
				end
				if (resp_ready) begin
					in_resp = 1'b0;
					if (exp_ch < 0) begin
						err_count++;
						$display("error at %0t: response on channel %0d with no open request",
							$time, resp_ch);
					end else begin
						model_apply(mem_port_pkg::chan_t'(exp_ch), pend_op[exp_ch],
							pend_adr[exp_ch], pend_wdata[exp_ch], acc_cyc[exp_ch] + 1,
							exp_rdata, exp_status);
						if (resp_ch != mem_port_pkg::chan_t'(exp_ch)) begin
							report_mismatch("resp_ch", 32'(exp_ch), 32'(resp_ch));
						end
						if (resp_rdata != exp_rdata) begin
							report_mismatch("resp_rdata", exp_rdata, resp_rdata);
						end
						if (resp_status != exp_status) begin
							report_mismatch("resp_status", 32'(exp_status), 32'(resp_status));
						end
						n_answered[exp_ch]++;
						last_ch = exp_ch;
						n_checks++;
					end
				end
			end
		end
	end

	// Allowance of 40 cycles per issued request plus room for reset and idle gaps
	initial begin
		while (cyc <= n_total * 40 + 2000) begin
			@(posedge clk);
		end
		$display("timeout: the DUT stopped answering requests at %0t", $time);
		$display("ERRORS FOUND");
		$finish;
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================

	task automatic prepare(input int ch, input mem_port_pkg::op_t op,
		input mem_port_pkg::adr_t adr, input mem_port_pkg::data_t wdata);
		pend_op[ch] = op;
		pend_adr[ch] = adr;
		pend_wdata[ch] = wdata;
	endtask

	// Raises valid on every masked channel at once and drops each one at its accept edge
	task automatic issue_set(input logic [mem_port_pkg::NCH-1:0] mask);
		logic [mem_port_pkg::NCH-1:0] left;
		logic [mem_port_pkg::NCH-1:0] taken;
		@(posedge clk);
		for (int c = 0; c < mem_port_pkg::NCH; c++) begin
			if (mask[c]) begin
				req_valid[c] <= 1'b1;
				req_op[c*mem_port_pkg::OP_W +: mem_port_pkg::OP_W] <= pend_op[c];
				req_adr[c*mem_port_pkg::ADR_W +: mem_port_pkg::ADR_W] <= pend_adr[c];
				req_wdata[c*mem_port_pkg::DAT_W +: mem_port_pkg::DAT_W] <= pend_wdata[c];
				n_issued[c]++;
				n_total++;
			end
		end
		left = mask;
		while (left != '0) begin
			@(negedge clk);
			taken = req_ready & left;
			// Cycle in which ready and valid meet for each channel taken
			for (int c = 0; c < mem_port_pkg::NCH; c++) begin
				if (taken[c]) begin
					acc_cyc[c] = cyc;
				end
			end
			@(posedge clk);
			for (int c = 0; c < mem_port_pkg::NCH; c++) begin
				if (taken[c]) begin
					req_valid[c] <= 1'b0;
				end
			end
			left = left & ~taken;
		end
	endtask

	task automatic wait_answers();
		while (count_outstanding() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic do_req(input int ch, input mem_port_pkg::op_t op,
		input mem_port_pkg::adr_t adr, input mem_port_pkg::data_t wdata);
		logic [mem_port_pkg::NCH-1:0] mask;
		mask = '0;
		mask[ch] = 1'b1;
		prepare(ch, op, adr, wdata);
		issue_set(mask);
		wait_answers();
	endtask

	// The new timeout is live from the second edge, before any later request
	task automatic set_tmo(input mem_port_pkg::tmo_t value);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_tmo <= value;
		@(posedge clk);
		cfg_we <= 1'b0;
		m_tmo = value;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		wait_answers();
		$display("test %s: done, %0d errors", name, err_count - test_base);
		test_base = err_count;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		mem_port_pkg::adr_t a;
		mem_port_pkg::data_t d;
		int ch;
		void'($urandom(32'he062));
		rst = 1'b1;
		req_valid = '0;
		req_op = '0;
		req_adr = '0;
		req_wdata = '0;
		cfg_we = 1'b0;
		cfg_tmo = '0;
		bp_en = 1'b0;
		m_tmo = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// Every word gets a known value first, so later reads are always defined
		for (int i = 0; i < mem_port_pkg::MEM_WORDS; i++) begin
			a = mem_port_pkg::adr_t'(i * 4);
			do_req(i % 4, mem_port_pkg::OP_WRITE, a, fill_word(a));
		end
		for (int k = 0; k < 12; k++) begin
			a = mem_port_pkg::adr_t'(($urandom % 256) * 4);
			d = $urandom;
			ch = int'($urandom % 4);
			do_req(ch, mem_port_pkg::OP_WRITE, a, d);
			do_req((ch + 1) % 4, mem_port_pkg::OP_READ, a, '0);
		end
		end_test("1 write and read");

		do_req(1, mem_port_pkg::OP_LR, 32'h100, '0);
		do_req(1, mem_port_pkg::OP_SC, 32'h100, 32'h1111_0002);
		do_req(1, mem_port_pkg::OP_READ, 32'h100, '0);
		// Its own successful store used up the reservation
		do_req(1, mem_port_pkg::OP_SC, 32'h100, 32'h2222_0002);
		do_req(2, mem_port_pkg::OP_SC, 32'h200, 32'h3333_0002);
		do_req(0, mem_port_pkg::OP_READ, 32'h100, '0);
		do_req(0, mem_port_pkg::OP_READ, 32'h200, '0);
		end_test("2 reserve and conditional store");

		do_req(0, mem_port_pkg::OP_LR, 32'h300, '0);
		do_req(2, mem_port_pkg::OP_WRITE, 32'h304, 32'h4444_0003);
		do_req(0, mem_port_pkg::OP_SC, 32'h300, 32'h5555_0003);
		do_req(0, mem_port_pkg::OP_LR, 32'h340, '0);
		do_req(2, mem_port_pkg::OP_WRITE, 32'h380, 32'h6666_0003);
		do_req(0, mem_port_pkg::OP_SC, 32'h344, 32'h7777_0003);
		do_req(3, mem_port_pkg::OP_READ, 32'h300, '0);
		do_req(3, mem_port_pkg::OP_READ, 32'h344, '0);
		end_test("3 clear on foreign write");

		do_req(0, mem_port_pkg::OP_LR, 32'h080, '0);
		do_req(1, mem_port_pkg::OP_LR, 32'h090, '0);
		// Held line again, so no bucket moves
		do_req(0, mem_port_pkg::OP_LR, 32'h080, '0);
		// Channel 2 now takes the victim bucket and channel 1 keeps its line
		do_req(2, mem_port_pkg::OP_LR, 32'h0a0, '0);
		for (int c = 0; c < mem_port_pkg::NCH; c++) begin
			a = mem_port_pkg::adr_t'(32'h080 + c * 16);
			do_req(c, mem_port_pkg::OP_SC, a, 32'h8000_0004 + c);
			do_req((c + 2) % 4, mem_port_pkg::OP_READ, a, '0);
		end
		end_test("4 victim replacement");

		// Random mix from all four channels on four shared lines
		bp_en = 1'b1;
		repeat (6) begin
			for (int c = 0; c < mem_port_pkg::NCH; c++) begin
				prepare(c, mem_port_pkg::op_t'($urandom % 4),
					mem_port_pkg::adr_t'(32'h0c0 + ($urandom % 16) * 4), $urandom);
			end
			issue_set('1);
			wait_answers();
		end
		bp_en = 1'b0;
		end_test("5 contention with back-pressure");

		set_tmo(16'd8);
		do_req(2, mem_port_pkg::OP_LR, 32'h1d0, '0);
		idle(40);
		do_req(2, mem_port_pkg::OP_SC, 32'h1d0, 32'h9999_0006);
		do_req(2, mem_port_pkg::OP_READ, 32'h1d0, '0);
		set_tmo(16'd0);
		do_req(3, mem_port_pkg::OP_LR, 32'h1c0, '0);
		idle(300);
		do_req(3, mem_port_pkg::OP_SC, 32'h1c0, 32'haaaa_0006);
		do_req(3, mem_port_pkg::OP_READ, 32'h1c0, '0);
		end_test("6 reservation timeout");

		$display("%0d responses checked, %0d errors", n_checks, err_count);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
